/* rtl/icache_settings.svh */
`ifndef ICACHE_SETTINGS_SVH
`define ICACHE_SETTINGS_SVH

// byte address and data word widths
`define ICACHE_ADDR_W 32
`define ICACHE_WORD_W 32

// 8 KB direct mapped, 64 byte lines
// address splits as tag | index | offset
`define ICACHE_OFFSET_W 6
`define ICACHE_INDEX_W 7
`define ICACHE_TAG_W 19

// 16 words per line, one beat per word
`define ICACHE_LINE_WORDS 16
`define ICACHE_WORD_SEL_W 4

// memory side length code, beats minus one
`define ICACHE_BURST_LEN_W 8

// top nibble of the uncached region
// reads there bypass the arrays
`define ICACHE_UNCACHE_CODE 4'hA

`endif

/* rtl/icache_pkg.sv */
`include "icache_settings.svh"

package icache_pkg;

  // byte address as seen by requester and memory
  typedef logic [`ICACHE_ADDR_W-1:0] addr_t;

  // instruction or memory data word
  typedef logic [`ICACHE_WORD_W-1:0] word_t;

  // line tag and line index
  typedef logic [`ICACHE_TAG_W-1:0] tag_t;
  typedef logic [`ICACHE_INDEX_W-1:0] index_t;

  // word within a line, doubles as refill beat number
  typedef logic [`ICACHE_WORD_SEL_W-1:0] word_sel_t;

  // burst length code on the memory side
  typedef logic [`ICACHE_BURST_LEN_W-1:0] burst_len_t;

  // controller states
  typedef enum logic [1:0] {
    FETCH_IDLE     = 2'd0,
    FETCH_LOOKUP   = 2'd1,
    FETCH_REFILL   = 2'd2,
    FETCH_UNCACHED = 2'd3
  } fetch_state_t;

endpackage

/* rtl/icache_tag_store.sv */
`timescale 1ns/100ps
`include "icache_settings.svh"

module icache_tag_store
  import icache_pkg::*;
(
  input  logic   clk,
  input  logic   rst,
  // line selected by the captured address
  input  index_t index_i,
  input  tag_t   tag_i,
  // set tag and valid after a completed refill
  input  logic   wr_i,
  // valid entry with matching tag
  output logic   hit_o
);

  localparam int LINES = 1 << `ICACHE_INDEX_W;

  // one tag per line
  tag_t tag_mem [LINES];

  // valid bits are control state, cleared on reset
  logic [LINES-1:0] valid_q;

  // tag array, written once per refill
  always_ff @(posedge clk) begin
    if (wr_i) begin
      tag_mem[index_i] <= tag_i;
    end
  end

  // valid bits
  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= '0;
    end else if (wr_i) begin
      valid_q[index_i] <= 1'b1;
    end
  end

  // compare on stored contents only
  // a write in this cycle shows up next cycle
  assign hit_o = valid_q[index_i] && (tag_mem[index_i] == tag_i);

  // controller raises the tag write for exactly one cycle per refill
  a_tag_wr_pulse : assert property (
    @(posedge clk) disable iff (rst)
    wr_i |=> !wr_i
  );

endmodule

/* rtl/icache_data_store.sv */
`timescale 1ns/100ps
`include "icache_settings.svh"

module icache_data_store
  import icache_pkg::*;
(
  input  logic      clk,
  // line being looked up or refilled
  input  index_t    index_i,
  // word to read within the line
  input  word_sel_t word_sel_i,
  // refill beat write
  input  logic      wr_i,
  input  word_sel_t beat_i,
  input  word_t     wdata_i,
  // word at index_i / word_sel_i
  output word_t     rdata_o
);

  localparam int LINES = 1 << `ICACHE_INDEX_W;
  localparam int DEPTH = LINES * `ICACHE_LINE_WORDS;
  localparam int ADDR_W = `ICACHE_INDEX_W + `ICACHE_WORD_SEL_W;

  // flat word array, line major
  word_t data_mem [DEPTH];

  logic [ADDR_W-1:0] wr_addr;
  logic [ADDR_W-1:0] rd_addr;

  // line index on top, word number below
  assign wr_addr = {index_i, beat_i};
  assign rd_addr = {index_i, word_sel_i};

  // one word per accepted beat
  always_ff @(posedge clk) begin
    if (wr_i) begin
      data_mem[wr_addr] <= wdata_i;
    end
  end

  // asynchronous read, sampled by the controller in lookup
  assign rdata_o = data_mem[rd_addr];

endmodule

/* rtl/icache_fetch_ctrl.sv */
`timescale 1ns/100ps
`include "icache_settings.svh"

module icache_fetch_ctrl
  import icache_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  // requester side
  input  addr_t      preif_raddr_i,
  input  logic       preif_raddr_valid_i,
  output word_t      if_rdata_o,
  output logic       if_rdata_valid_o,
  // memory side
  output addr_t      ram_raddr_o,
  output logic       ram_raddr_valid_o,
  output burst_len_t ram_rlen_o,
  input  logic       ram_rdata_ready_i,
  input  word_t      ram_rdata_i,
  // tag store
  output tag_t       tag_o,
  output index_t     index_o,
  output logic       tag_wr_o,
  input  logic       hit_i,
  // data store
  output word_sel_t  word_sel_o,
  output logic       data_wr_o,
  output word_sel_t  beat_o,
  output word_t      beat_data_o,
  input  word_t      rd_word_i
);

  localparam word_sel_t LAST_BEAT = word_sel_t'(`ICACHE_LINE_WORDS - 1);
  localparam burst_len_t LINE_LEN = burst_len_t'(`ICACHE_LINE_WORDS - 1);
  localparam burst_len_t SINGLE_LEN = '0;

  fetch_state_t state_q;

  // captured request address, held for the whole access
  addr_t addr_q;

  // refill beat counter
  word_sel_t beat_q;

  logic uncached;
  logic beat_acc;
  logic last_beat;

  // split of the captured address
  assign tag_o = addr_q[`ICACHE_ADDR_W-1 -: `ICACHE_TAG_W];
  assign index_o = addr_q[`ICACHE_OFFSET_W +: `ICACHE_INDEX_W];
  assign word_sel_o = addr_q[2 +: `ICACHE_WORD_SEL_W];

  // region check on the top nibble
  assign uncached = (addr_q[`ICACHE_ADDR_W-1 -: 4] == `ICACHE_UNCACHE_CODE);

  // beat taken at this edge
  assign beat_acc = ram_raddr_valid_o && ram_rdata_ready_i;
  assign last_beat = beat_acc && (beat_q == LAST_BEAT);

  // refill writes go straight from the memory bus to the array
  assign data_wr_o = (state_q == FETCH_REFILL) && beat_acc;
  assign beat_o = beat_q;
  assign beat_data_o = ram_rdata_i;

  // main sequencer
  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= FETCH_IDLE;
      if_rdata_valid_o <= 1'b0;
      ram_raddr_valid_o <= 1'b0;
      tag_wr_o <= 1'b0;
      beat_q <= '0;
    end else begin
      // single cycle strobes by default
      if_rdata_valid_o <= 1'b0;
      tag_wr_o <= 1'b0;
      case (state_q)
        FETCH_IDLE: begin
          // skip the pulse cycle, requester still shows the old address
          if (preif_raddr_valid_i && !if_rdata_valid_o) begin
            state_q <= FETCH_LOOKUP;
          end
        end
        FETCH_LOOKUP: begin
          if (uncached) begin
            // single beat, never allocated
            state_q <= FETCH_UNCACHED;
            ram_raddr_valid_o <= 1'b1;
          end else if (hit_i) begin
            // answer registered out of lookup
            state_q <= FETCH_IDLE;
            if_rdata_valid_o <= 1'b1;
          end else begin
            // whole line from its base
            state_q <= FETCH_REFILL;
            ram_raddr_valid_o <= 1'b1;
            beat_q <= '0;
          end
        end
        FETCH_REFILL: begin
          if (tag_wr_o) begin
            // tag now written, look up again and hit
            state_q <= FETCH_LOOKUP;
          end else if (last_beat) begin
            ram_raddr_valid_o <= 1'b0;
            tag_wr_o <= 1'b1;
          end else if (beat_acc) begin
            beat_q <= beat_q + 1'b1;
          end
        end
        FETCH_UNCACHED: begin
          if (beat_acc) begin
            // word goes out the cycle after its beat
            state_q <= FETCH_IDLE;
            ram_raddr_valid_o <= 1'b0;
            if_rdata_valid_o <= 1'b1;
          end
        end
        default: begin
          state_q <= FETCH_IDLE;
        end
      endcase
    end
  end

  // request address, loaded in idle only
  always_ff @(posedge clk) begin
    if (state_q == FETCH_IDLE && preif_raddr_valid_i) begin
      addr_q <= preif_raddr_i;
    end
  end

  // memory request payload, set when leaving lookup
  always_ff @(posedge clk) begin
    if (state_q == FETCH_LOOKUP) begin
      if (uncached) begin
        // aligned word address
        ram_raddr_o <= {addr_q[`ICACHE_ADDR_W-1:2], 2'b00};
        ram_rlen_o <= SINGLE_LEN;
      end else begin
        // line base
        ram_raddr_o <= {tag_o, index_o, {`ICACHE_OFFSET_W{1'b0}}};
        ram_rlen_o <= LINE_LEN;
      end
    end
  end

  // return word
  // hit takes the array word, uncached takes the beat
  always_ff @(posedge clk) begin
    if (state_q == FETCH_LOOKUP && hit_i && !uncached) begin
      if_rdata_o <= rd_word_i;
    end else if (state_q == FETCH_UNCACHED && beat_acc) begin
      if_rdata_o <= ram_rdata_i;
    end
  end

  // memory is only requested once lookup has decided
  a_no_req_idle_lookup : assert property (
    @(posedge clk) disable iff (rst)
    (state_q == FETCH_IDLE || state_q == FETCH_LOOKUP) |-> !ram_raddr_valid_o
  );

  // one answer per request, never a held valid
  a_rdata_valid_pulse : assert property (
    @(posedge clk) disable iff (rst)
    if_rdata_valid_o |=> !if_rdata_valid_o
  );

endmodule

/* rtl/icache_top.sv */
`timescale 1ns/100ps
`include "icache_settings.svh"

module icache_top
  import icache_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  // fetch address from the requester, held until the answer
  input  addr_t      preif_raddr_i,
  input  logic       preif_raddr_valid_i,
  // one cycle answer
  output word_t      if_rdata_o,
  output logic       if_rdata_valid_o,
  // read request to memory, level until last beat
  output addr_t      ram_raddr_o,
  output logic       ram_raddr_valid_o,
  output burst_len_t ram_rlen_o,
  // one strobe per returned beat
  input  logic       ram_rdata_ready_i,
  input  word_t      ram_rdata_i
);

  // tag store hookup
  tag_t      lookup_tag;
  index_t    lookup_index;
  logic      tag_wr;
  logic      tag_hit;

  // data store hookup
  word_sel_t rd_word_sel;
  word_t     rd_word;
  logic      data_wr;
  word_sel_t refill_beat;
  word_t     refill_data;

  // sequencer for capture, lookup, refill and return
  icache_fetch_ctrl u_fetch_ctrl (
    .clk                 (clk),
    .rst                 (rst),
    .preif_raddr_i       (preif_raddr_i),
    .preif_raddr_valid_i (preif_raddr_valid_i),
    .if_rdata_o          (if_rdata_o),
    .if_rdata_valid_o    (if_rdata_valid_o),
    .ram_raddr_o         (ram_raddr_o),
    .ram_raddr_valid_o   (ram_raddr_valid_o),
    .ram_rlen_o          (ram_rlen_o),
    .ram_rdata_ready_i   (ram_rdata_ready_i),
    .ram_rdata_i         (ram_rdata_i),
    .tag_o               (lookup_tag),
    .index_o             (lookup_index),
    .tag_wr_o            (tag_wr),
    .hit_i               (tag_hit),
    .word_sel_o          (rd_word_sel),
    .data_wr_o           (data_wr),
    .beat_o              (refill_beat),
    .beat_data_o         (refill_data),
    .rd_word_i           (rd_word)
  );

  // tags and valid bits
  icache_tag_store u_tag_store (
    .clk     (clk),
    .rst     (rst),
    .index_i (lookup_index),
    .tag_i   (lookup_tag),
    .wr_i    (tag_wr),
    .hit_o   (tag_hit)
  );

  // line words, same index for read and refill
  icache_data_store u_data_store (
    .clk        (clk),
    .index_i    (lookup_index),
    .word_sel_i (rd_word_sel),
    .wr_i       (data_wr),
    .beat_i     (refill_beat),
    .wdata_i    (refill_data),
    .rdata_o    (rd_word)
  );

endmodule

/* bench/icache_mem_model.sv */
`timescale 1ns/100ps
`include "icache_settings.svh"

module icache_mem_model
  import icache_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  // read request from the cache
  input  addr_t      raddr_i,
  input  logic       raddr_valid_i,
  input  burst_len_t rlen_i,
  // one strobe per beat
  output logic       rdata_ready_o,
  output word_t      rdata_o,
  // bookkeeping seen by the bench
  output int         line_count_o,
  output int         uncached_count_o,
  output burst_len_t last_len_o
);

  localparam logic [31:0] LINE_XOR = 32'hc3a50f96;
  localparam burst_len_t LINE_LEN = burst_len_t'(`ICACHE_LINE_WORDS - 1);

  logic        busy;
  addr_t       base_q;
  burst_len_t  len_q;
  int          beat_q;
  int          gap_q;
  logic [31:0] seed_q;
  addr_t       beat_addr;

  // classic 32 bit lcg
  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  // known levels before the first reset edge
  initial begin
    rdata_ready_o = 1'b0;
    rdata_o = '0;
  end

  // beats change on the falling edge, cache samples on the rising one
  always @(negedge clk) begin
    rdata_ready_o = 1'b0;
    if (rst) begin
      busy = 1'b0;
      beat_q = 0;
      gap_q = 0;
      seed_q = 32'h96b3;
      line_count_o = 0;
      uncached_count_o = 0;
      last_len_o = '0;
      rdata_o = '0;
    end else if (!busy) begin
      if (raddr_valid_i) begin
        // new request, first gap chosen now
        busy = 1'b1;
        base_q = raddr_i;
        len_q = rlen_i;
        last_len_o = rlen_i;
        beat_q = 0;
        seed_q = lcg_next(seed_q);
        gap_q = int'(seed_q[17:16]);
        if (rlen_i == LINE_LEN) begin
          line_count_o = line_count_o + 1;
        end
      end
    end else if (gap_q > 0) begin
      // back-pressure
      gap_q = gap_q - 1;
    end else begin
      beat_addr = base_q + addr_t'(beat_q * 4);
      rdata_ready_o = 1'b1;
      // uncached data depends on how many were served before
      if (len_q == '0) begin
        rdata_o = beat_addr ^ uncached_count_o;
      end else begin
        rdata_o = beat_addr ^ LINE_XOR;
      end
      if (beat_q == int'(len_q)) begin
        busy = 1'b0;
        if (len_q == '0) begin
          uncached_count_o = uncached_count_o + 1;
        end
      end else begin
        beat_q = beat_q + 1;
        seed_q = lcg_next(seed_q);
        gap_q = int'(seed_q[17:16]);
      end
    end
  end

endmodule

/* bench/icache_tb.sv */
`timescale 1ns/100ps
`include "icache_settings.svh"

module icache_tb
  import icache_pkg::*;
();

  localparam int MAX_TESTS = 32;
  localparam int TIMEOUT = 400;
  localparam logic [31:0] LINE_XOR = 32'hc3a50f96;

  logic       clk;
  logic       rst;
  addr_t      preif_raddr;
  logic       preif_raddr_valid;
  word_t      if_rdata;
  logic       if_rdata_valid;
  addr_t      ram_raddr;
  logic       ram_raddr_valid;
  burst_len_t ram_rlen;
  logic       ram_rdata_ready;
  word_t      ram_rdata;
  int         line_count;
  int         uncached_count;
  burst_len_t last_len;

  // stimulus table, name / address / line bursts after the access
  string test_name [MAX_TESTS];
  addr_t test_addr [MAX_TESTS];
  int    test_bursts [MAX_TESTS];
  int    num_tests;

  int    i;
  int    latency;
  int    prev_bursts;
  int    unc_reads;
  word_t got;
  word_t expect_word;
  addr_t aligned;
  logic  is_uncached;

  icache_top u_icache_top (
    .clk                 (clk),
    .rst                 (rst),
    .preif_raddr_i       (preif_raddr),
    .preif_raddr_valid_i (preif_raddr_valid),
    .if_rdata_o          (if_rdata),
    .if_rdata_valid_o    (if_rdata_valid),
    .ram_raddr_o         (ram_raddr),
    .ram_raddr_valid_o   (ram_raddr_valid),
    .ram_rlen_o          (ram_rlen),
    .ram_rdata_ready_i   (ram_rdata_ready),
    .ram_rdata_i         (ram_rdata)
  );

  icache_mem_model u_mem (
    .clk              (clk),
    .rst              (rst),
    .raddr_i          (ram_raddr),
    .raddr_valid_i    (ram_raddr_valid),
    .rlen_i           (ram_rlen),
    .rdata_ready_o    (ram_rdata_ready),
    .rdata_o          (ram_rdata),
    .line_count_o     (line_count),
    .uncached_count_o (uncached_count),
    .last_len_o       (last_len)
  );

  // 40 ns period
  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("RESULT: FAIL");
    $fatal(1, "stopped at first error");
  endtask

  task automatic compare_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
    if (exp !== act) begin
      abort_run($sformatf("mismatch %s: expected %h, actual %h", name, exp, act));
    end
  endtask

  task automatic add_test(input string name, input addr_t addr, input int bursts);
    test_name[num_tests] = name;
    test_addr[num_tests] = addr;
    test_bursts[num_tests] = bursts;
    num_tests = num_tests + 1;
  endtask

  // one request, held until the valid pulse
  // cycles counts falling edges from the drive to the pulse
  task automatic read_word(input string name, input addr_t addr,
                           output word_t data, output int cycles);
    logic seen;
    @(negedge clk);
    preif_raddr = addr;
    preif_raddr_valid = 1'b1;
    cycles = 0;
    seen = 1'b0;
    while (!seen) begin
      @(negedge clk);
      cycles = cycles + 1;
      if (if_rdata_valid) begin
        seen = 1'b1;
      end else if (cycles >= TIMEOUT) begin
        abort_run($sformatf("timeout: no read data arrived for %s within %0d cycles",
                            name, TIMEOUT));
      end
    end
    data = if_rdata;
    // pulse is over at the next falling edge
    @(negedge clk);
    preif_raddr_valid = 1'b0;
  endtask

  initial begin
    rst = 1'b1;
    preif_raddr = '0;
    preif_raddr_valid = 1'b0;
    num_tests = 0;

    // cold miss, then a hit in the same line
    add_test("cold miss", 32'h0000_1044, 1);
    add_test("same line hit", 32'h0000_1078, 1);
    // same index 0x41, other tag
    add_test("conflict miss", 32'h0000_3044, 2);
    add_test("evicted reread", 32'h0000_1044, 3);
    // uncached region, never allocated
    add_test("uncached first", 32'hA000_0120, 3);
    add_test("uncached second", 32'hA000_0120, 3);
    // whole line, starting mid line so the miss is on word 9
    for (i = 0; i < `ICACHE_LINE_WORDS; i++) begin
      add_test("full line", 32'h0002_0800 + addr_t'(((i + 9) % 16) * 4), 4);
    end

    repeat (2) @(negedge clk);
    rst = 1'b0;

    // quiet outputs before any request
    for (i = 0; i < 4; i++) begin
      @(negedge clk);
      compare_value("idle rdata valid", 32'd0, 32'(if_rdata_valid));
      compare_value("idle ram valid", 32'd0, 32'(ram_raddr_valid));
    end

    prev_bursts = 0;
    unc_reads = 0;
    for (i = 0; i < num_tests; i++) begin
      read_word(test_name[i], test_addr[i], got, latency);
      aligned = {test_addr[i][31:2], 2'b00};
      is_uncached = (test_addr[i][31:28] == `ICACHE_UNCACHE_CODE);
      // expected word from the memory data rule
      if (is_uncached) begin
        expect_word = aligned ^ 32'(unc_reads);
        unc_reads = unc_reads + 1;
      end else begin
        expect_word = aligned ^ LINE_XOR;
      end
      compare_value(test_name[i], expect_word, got);
      compare_value({test_name[i], " bursts"}, 32'(test_bursts[i]), 32'(line_count));
      if (is_uncached) begin
        compare_value({test_name[i], " length"}, 32'd0, 32'(last_len));
        compare_value({test_name[i], " uncached count"}, 32'(unc_reads),
                      32'(uncached_count));
      end else if (test_bursts[i] != prev_bursts) begin
        // refill is one full line burst
        compare_value({test_name[i], " length"}, 32'd15, 32'(last_len));
      end else begin
        // hit answers in the second cycle
        compare_value({test_name[i], " latency"}, 32'd2, 32'(latency));
      end
      prev_bursts = test_bursts[i];
    end

    $display("RESULT: PASS");
    $finish;
  end

endmodule

/* sources.f */
+incdir+rtl
rtl/icache_pkg.sv
rtl/icache_tag_store.sv
rtl/icache_data_store.sv
rtl/icache_fetch_ctrl.sv
rtl/icache_top.sv
bench/icache_mem_model.sv
bench/icache_tb.sv
